/* verilog/board_pkg.sv */
// row 0 is the top of the well and columns grow to the right; the well is fixed at 20 by 10
package board_pkg;

    localparam int PLAYFIELD_ROWS = 20;
    localparam int PLAYFIELD_COLS = 10;

    // origin and cell coordinates
    typedef logic [4:0] row_t;

    // signed so that a candidate left of the wall stays representable
    typedef logic signed [4:0] col_t;

    // bit 0 is column 0
    typedef logic [PLAYFIELD_COLS-1:0] row_cells_t;

    // whole well, indexed by row
    typedef row_cells_t [PLAYFIELD_ROWS-1:0] field_t;

    // every new piece enters here
    localparam row_t SPAWN_ROW = 5'd0;
    localparam col_t SPAWN_COL = 5'sd3;

endpackage

/* verilog/tetromino_pkg.sv */
// shapes follow SRS inside a 4 by 4 box whose top-left corner is the piece origin
package tetromino_pkg;

    typedef enum logic [2:0] {
        I, O, T, S, Z, J, L
    } tile_type_t;

    // rotating right steps forward and wraps
    typedef enum logic [1:0] {
        SPAWN, RIGHT, FLIP, LEFT
    } orientation_t;

    typedef enum logic [2:0] {
        NONE, MOVE_L, MOVE_R, ROT_L, ROT_R, SOFT, HARD
    } action_t;

    localparam int CELLS_PER_PIECE = 4;
    localparam int TILE_TYPES      = 7;
    localparam int ACTION_COUNT    = 6;

    // bag bit n stands for the piece with code n
    typedef logic [TILE_TYPES-1:0] bag_t;
    localparam bag_t        BAG_FULL = 7'h7F;
    localparam logic [15:0] BAG_SEED = 16'hACE1;

    typedef struct packed {
        logic [CELLS_PER_PIECE-1:0][1:0] row;
        logic [CELLS_PER_PIECE-1:0][1:0] col;
    } shape_t;

    // box occupancy, bit 4*row + col, indexed by {type, orientation}
    localparam logic [15:0] SHAPE_MASKS [TILE_TYPES*4] = '{
        16'h00F0, 16'h4444, 16'h0F00, 16'h2222,
        16'h0066, 16'h0066, 16'h0066, 16'h0066,
        16'h0072, 16'h0262, 16'h0270, 16'h0232,
        16'h0036, 16'h0462, 16'h0360, 16'h0231,
        16'h0063, 16'h0264, 16'h0630, 16'h0132,
        16'h0071, 16'h0226, 16'h0470, 16'h0322,
        16'h0074, 16'h0622, 16'h0170, 16'h0223
    };

    // row and column offsets of the four cells, in scan order
    function automatic shape_t shape_cells(tile_type_t kind, orientation_t orient);
        logic [15:0] mask;
        shape_t      shape;
        int          n;
        mask  = SHAPE_MASKS[{kind, orient}];
        shape = '0;
        n     = 0;
        for (int b = 0; b < 16; b++) begin
            if (mask[b] && n < CELLS_PER_PIECE) begin
                shape.row[n] = 2'(b / 4);
                shape.col[n] = 2'(b % 4);
                n++;
            end
        end
        return shape;
    endfunction

endpackage

/* verilog/piece_if.sv */
// the owner side is the only driver of the piece state; viewers may only read it
`timescale 1ns/100ps

interface piece_if;
    import board_pkg::*;
    import tetromino_pkg::*;

    // origin of the 4 by 4 box
    row_t         row;
    col_t         col;
    orientation_t orientation;
    tile_type_t   kind;

    modport owner (
        output row,
        output col,
        output orientation,
        output kind
    );

    modport viewer (
        input row,
        input col,
        input orientation,
        input kind
    );

endinterface

/* verilog/key_conditioner.sv */
// buttons are active low; a press inside its action's cooldown is lost, never deferred
`timescale 1ns/100ps

module key_conditioner #(
    parameter int COOLDOWN_CYCLES = 10_000_000
) (
    input  logic                   clk,
    input  logic                   rst_l,
    input  logic                   key_left,
    input  logic                   key_right,
    input  logic                   key_soft,
    input  logic                   key_hard,
    input  logic                   rotate_mode,
    output tetromino_pkg::action_t action
);
    import tetromino_pkg::*;

    localparam int CD_W = $clog2(COOLDOWN_CYCLES + 1);

    // key order is left, right, soft, hard
    logic [3:0]            sync_1;
    logic [3:0]            sync_2;
    logic [3:0]            held;
    logic [3:0]            rise;
    logic [ACTION_COUNT:1] req;
    logic [ACTION_COUNT:1] go;
    logic [CD_W-1:0]       cd [ACTION_COUNT:1];
    action_t               pick;

    assign rise = sync_2 & ~held;

    // left and right keys turn into rotations in rotate mode
    always_comb begin
        req         = '0;
        req[MOVE_L] = rise[0] && !rotate_mode;
        req[MOVE_R] = rise[1] && !rotate_mode;
        req[ROT_L]  = rise[0] && rotate_mode;
        req[ROT_R]  = rise[1] && rotate_mode;
        req[SOFT]   = rise[2];
        req[HARD]   = rise[3];
        for (int a = 1; a <= ACTION_COUNT; a++) begin
            go[a] = req[a] && (cd[a] == '0);
        end
    end

    // hard, soft, move, rotate
    always_comb begin
        pick = NONE;
        if (go[HARD]) begin
            pick = HARD;
        end else if (go[SOFT]) begin
            pick = SOFT;
        end else if (go[MOVE_L]) begin
            pick = MOVE_L;
        end else if (go[MOVE_R]) begin
            pick = MOVE_R;
        end else if (go[ROT_L]) begin
            pick = ROT_L;
        end else if (go[ROT_R]) begin
            pick = ROT_R;
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            sync_1 <= '0;
            sync_2 <= '0;
            held   <= '0;
            action <= NONE;
            for (int a = 1; a <= ACTION_COUNT; a++) begin
                cd[a] <= '0;
            end
        end else begin
            sync_1 <= ~{key_hard, key_soft, key_right, key_left};
            sync_2 <= sync_1;
            held   <= sync_2;
            action <= pick;
            // only the issued action starts its cooldown
            for (int a = 1; a <= ACTION_COUNT; a++) begin
                if (int'(pick) == a) begin
                    cd[a] <= CD_W'(COOLDOWN_CYCLES);
                end else if (cd[a] != '0) begin
                    cd[a] <= cd[a] - 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/seven_bag.sv */
// draw is valid in the same cycle as spawn; the bag refills at once when it empties
`timescale 1ns/100ps

module seven_bag (
    input  logic                      clk,
    input  logic                      rst_l,
    input  logic                      spawn,
    output tetromino_pkg::tile_type_t draw,
    output tetromino_pkg::bag_t       remaining
);
    import tetromino_pkg::*;

    logic [15:0] lfsr;
    logic [2:0]  start;
    bag_t        take;
    bag_t        left_over;

    // fold the 8th code back onto the first piece
    assign start = (lfsr[2:0] == 3'd7) ? 3'd0 : lfsr[2:0];

    // first piece still in the bag, searching upward from start
    always_comb begin : pick_piece
        int   idx;
        logic found;
        draw  = I;
        take  = '0;
        found = 1'b0;
        for (int k = 0; k < TILE_TYPES; k++) begin
            idx = int'(start) + k;
            if (idx >= TILE_TYPES) begin
                idx = idx - TILE_TYPES;
            end
            if (!found && remaining[idx]) begin
                found     = 1'b1;
                draw      = tile_type_t'(idx);
                take[idx] = 1'b1;
            end
        end
    end

    assign left_over = remaining & ~take;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            lfsr      <= BAG_SEED;
            remaining <= BAG_FULL;
        end else begin
            // taps 16, 14, 13, 11
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            if (spawn) begin
                remaining <= (left_over == '0) ? BAG_FULL : left_over;
            end
        end
    end

endmodule

/* verilog/move_checker.sv */
// purely combinational; rotations get no wall kicks, so any rotation that collides is refused
`timescale 1ns/100ps

module move_checker (
    piece_if.viewer                piece,
    input  tetromino_pkg::action_t action,
    input  board_pkg::field_t      cells,
    output logic                   accept,
    output board_pkg::row_t        land_row,
    output logic                   spawn_blocked
);
    import board_pkg::*;
    import tetromino_pkg::*;

    row_t         cand_row;
    col_t         cand_col;
    orientation_t cand_ori;

    // all four cells inside the walls and on empty squares
    function automatic logic fits(field_t field, tile_type_t kind, orientation_t ori,
                                  row_t row, col_t col);
        shape_t shape;
        logic   ok;
        row_t   r;
        col_t   c;
        shape = shape_cells(kind, ori);
        ok    = 1'b1;
        for (int i = 0; i < CELLS_PER_PIECE; i++) begin
            r = row + row_t'(shape.row[i]);
            c = col + col_t'(shape.col[i]);
            if (r >= row_t'(PLAYFIELD_ROWS) || c < 0 || c >= col_t'(PLAYFIELD_COLS)) begin
                ok = 1'b0;
            end else if (field[r][c[3:0]]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    always_comb begin
        cand_row = piece.row;
        cand_col = piece.col;
        cand_ori = piece.orientation;
        case (action)
            MOVE_L:  cand_col = piece.col - col_t'(1);
            MOVE_R:  cand_col = piece.col + col_t'(1);
            ROT_L:   cand_ori = orientation_t'(piece.orientation - 2'd1);
            ROT_R:   cand_ori = orientation_t'(piece.orientation + 2'd1);
            SOFT:    cand_row = piece.row + row_t'(1);
            default: ;
        endcase
    end

    // hard drop always succeeds, possibly in place
    assign accept = (action == HARD) ||
                    ((action != NONE) &&
                     fits(cells, piece.kind, cand_ori, cand_row, cand_col));

    // walk down until the first row that does not fit
    always_comb begin : find_landing
        int   r;
        logic stop;
        land_row = piece.row;
        stop     = 1'b0;
        for (int i = 1; i < PLAYFIELD_ROWS; i++) begin
            r = int'(piece.row) + i;
            if (!stop) begin
                if (r < PLAYFIELD_ROWS &&
                    fits(cells, piece.kind, piece.orientation, row_t'(r), piece.col)) begin
                    land_row = row_t'(r);
                end else begin
                    stop = 1'b1;
                end
            end
        end
    end

    assign spawn_blocked = !fits(cells, piece.kind, SPAWN, SPAWN_ROW, SPAWN_COL);

endmodule

/* verilog/falling_piece.sv */
// strobes that arrive while a lock or spawn is pending are dropped, never queued
`timescale 1ns/100ps

module falling_piece (
    input  logic                      clk,
    input  logic                      rst_l,
    input  tetromino_pkg::action_t    action,
    input  logic                      accept,
    input  board_pkg::row_t           land_row,
    input  tetromino_pkg::tile_type_t draw,
    piece_if.owner                    piece,
    output logic                      lock,
    output logic                      spawn,
    output logic                      top_out,
    input  logic                      spawn_blocked
);
    import board_pkg::*;
    import tetromino_pkg::*;

    logic init_q;
    logic hard_q;
    logic lock_q;
    logic fresh_q;
    logic top_q;
    logic live;

    // a piece that just spawned into locked cells takes no more actions
    assign live    = !(init_q || hard_q || lock_q || top_q || (fresh_q && spawn_blocked));
    assign spawn   = init_q || lock_q;
    assign lock    = lock_q;
    assign top_out = top_q;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            init_q            <= 1'b1;
            hard_q            <= 1'b0;
            lock_q            <= 1'b0;
            fresh_q           <= 1'b0;
            top_q             <= 1'b0;
            piece.row         <= SPAWN_ROW;
            piece.col         <= SPAWN_COL;
            piece.orientation <= SPAWN;
            piece.kind        <= I;
        end else begin
            init_q  <= 1'b0;
            hard_q  <= live && (action == HARD);
            // a hard drop locks one cycle after landing
            lock_q  <= hard_q || (live && (action == SOFT) && !accept);
            fresh_q <= spawn;
            if (fresh_q && spawn_blocked) begin
                top_q <= 1'b1;
            end
            if (spawn) begin
                piece.row         <= SPAWN_ROW;
                piece.col         <= SPAWN_COL;
                piece.orientation <= SPAWN;
                piece.kind        <= draw;
            end else if (live && accept) begin
                case (action)
                    MOVE_L:  piece.col <= piece.col - col_t'(1);
                    MOVE_R:  piece.col <= piece.col + col_t'(1);
                    ROT_L:   piece.orientation <= orientation_t'(piece.orientation - 2'd1);
                    ROT_R:   piece.orientation <= orientation_t'(piece.orientation + 2'd1);
                    SOFT:    piece.row <= piece.row + row_t'(1);
                    HARD:    piece.row <= land_row;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* verilog/playfield.sv */
// no line clearing; probe rows past the bottom read as empty
`timescale 1ns/100ps

module playfield (
    input  logic                   clk,
    input  logic                   rst_l,
    piece_if.viewer                piece,
    input  logic                   lock,
    output board_pkg::field_t      cells,
    input  board_pkg::row_t        probe_row,
    output board_pkg::row_cells_t  probe_cells
);
    import board_pkg::*;
    import tetromino_pkg::*;

    shape_t shape;
    row_t   cell_row [CELLS_PER_PIECE];
    col_t   cell_col [CELLS_PER_PIECE];

    assign shape = shape_cells(piece.kind, piece.orientation);

    always_comb begin
        for (int i = 0; i < CELLS_PER_PIECE; i++) begin
            cell_row[i] = piece.row + row_t'(shape.row[i]);
            cell_col[i] = piece.col + col_t'(shape.col[i]);
        end
    end

    // a locking piece always fits, so every cell is on the board
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            cells <= '0;
        end else if (lock) begin
            for (int i = 0; i < CELLS_PER_PIECE; i++) begin
                cells[cell_row[i]][cell_col[i][3:0]] <= 1'b1;
            end
        end
    end

    assign probe_cells = (probe_row < row_t'(PLAYFIELD_ROWS)) ? cells[probe_row] : '0;

endmodule

/* verilog/tetris_core.sv */
// single-player core only; buttons are active low and COOLDOWN_CYCLES must be at least 1
`timescale 1ns/100ps

module tetris_core #(
    parameter int COOLDOWN_CYCLES = 10_000_000
) (
    input  logic                        clk,
    input  logic                        rst_l,
    input  logic                        key_left,
    input  logic                        key_right,
    input  logic                        key_soft,
    input  logic                        key_hard,
    input  logic                        rotate_mode,
    output tetromino_pkg::tile_type_t   piece_type,
    output board_pkg::row_t             piece_row,
    output board_pkg::col_t             piece_col,
    output tetromino_pkg::orientation_t piece_orientation,
    output logic                        lock,
    output logic                        top_out,
    output tetromino_pkg::bag_t         bag_remaining,
    input  board_pkg::row_t             probe_row,
    output board_pkg::row_cells_t       probe_cells
);
    import board_pkg::*;
    import tetromino_pkg::*;

    action_t    action;
    logic       accept;
    logic       spawn_blocked;
    logic       spawn;
    row_t       land_row;
    tile_type_t draw;
    field_t     cells;

    piece_if piece_bus ();

    key_conditioner #(
        .COOLDOWN_CYCLES (COOLDOWN_CYCLES)
    ) i_keys (
        .clk         (clk),
        .rst_l       (rst_l),
        .key_left    (key_left),
        .key_right   (key_right),
        .key_soft    (key_soft),
        .key_hard    (key_hard),
        .rotate_mode (rotate_mode),
        .action      (action)
    );

    move_checker i_checker (
        .piece         (piece_bus.viewer),
        .action        (action),
        .cells         (cells),
        .accept        (accept),
        .land_row      (land_row),
        .spawn_blocked (spawn_blocked)
    );

    falling_piece i_piece (
        .clk           (clk),
        .rst_l         (rst_l),
        .action        (action),
        .accept        (accept),
        .land_row      (land_row),
        .draw          (draw),
        .piece         (piece_bus.owner),
        .lock          (lock),
        .spawn         (spawn),
        .top_out       (top_out),
        .spawn_blocked (spawn_blocked)
    );

    playfield i_field (
        .clk         (clk),
        .rst_l       (rst_l),
        .piece       (piece_bus.viewer),
        .lock        (lock),
        .cells       (cells),
        .probe_row   (probe_row),
        .probe_cells (probe_cells)
    );

    seven_bag i_bag (
        .clk       (clk),
        .rst_l     (rst_l),
        .spawn     (spawn),
        .draw      (draw),
        .remaining (bag_remaining)
    );

    assign piece_type        = piece_bus.kind;
    assign piece_row         = piece_bus.row;
    assign piece_col         = piece_bus.col;
    assign piece_orientation = piece_bus.orientation;

endmodule

/* testbench/tb_tetris_props.sv */
// checks sample at the rising edge, so expected values must be set up half a cycle earlier
`timescale 1ns/100ps

module tb_tetris_props (
    input  logic                        clk,
    input  logic                        rst_l,
    input  logic [127:0]                test_name,
    input  tetromino_pkg::tile_type_t   piece_type,
    input  board_pkg::row_t             piece_row,
    input  board_pkg::col_t             piece_col,
    input  tetromino_pkg::orientation_t piece_orientation,
    input  logic                        lock,
    input  logic                        top_out,
    input  tetromino_pkg::bag_t         bag_remaining,
    input  board_pkg::row_cells_t       probe_cells,
    input  logic                        chk_piece,
    input  tetromino_pkg::tile_type_t   exp_kind,
    input  board_pkg::row_t             exp_row,
    input  board_pkg::col_t             exp_col,
    input  tetromino_pkg::orientation_t exp_ori,
    input  logic                        exp_top,
    input  logic                        chk_probe,
    input  board_pkg::row_cells_t       exp_cells,
    input  logic                        chk_bag,
    input  int                          exp_bag_count,
    input  logic                        chk_group,
    input  tetromino_pkg::bag_t         group_mask,
    output int                          errors
);
    import tetromino_pkg::*;

    int   count = 0;
    logic lock_prev;
    logic top_prev;

    assign errors = count;

    always @(posedge clk) begin
        if (chk_piece) begin
            assert (piece_type == exp_kind) else begin
                $display("FAILED %0s: type expected %0s actual %0s", test_name,
                         exp_kind.name(), piece_type.name());
                count = count + 1;
            end
            assert (piece_row == exp_row) else begin
                $display("FAILED %0s: row expected %0d actual %0d", test_name, exp_row, piece_row);
                count = count + 1;
            end
            assert (piece_col == exp_col) else begin
                $display("FAILED %0s: col expected %0d actual %0d", test_name,
                         $signed(exp_col), $signed(piece_col));
                count = count + 1;
            end
            assert (piece_orientation == exp_ori) else begin
                $display("FAILED %0s: orientation expected %0s actual %0s", test_name,
                         exp_ori.name(), piece_orientation.name());
                count = count + 1;
            end
            assert (top_out == exp_top) else begin
                $display("FAILED %0s: top_out expected %0b actual %0b", test_name,
                         exp_top, top_out);
                count = count + 1;
            end
        end
        if (chk_probe) begin
            assert (probe_cells == exp_cells) else begin
                $display("FAILED %0s: probe row expected %b actual %b", test_name,
                         exp_cells, probe_cells);
                count = count + 1;
            end
        end
        if (chk_bag) begin
            assert ($countones(bag_remaining) == exp_bag_count) else begin
                $display("FAILED %0s: bag count expected %0d actual %0d", test_name,
                         exp_bag_count, $countones(bag_remaining));
                count = count + 1;
            end
        end
        if (chk_group) begin
            assert (group_mask == BAG_FULL) else begin
                $display("FAILED %0s: bag group expected %b actual %b", test_name,
                         BAG_FULL, group_mask);
                count = count + 1;
            end
        end
        // lock is a one-cycle pulse and top_out never falls outside reset
        assert (!(rst_l && lock && lock_prev)) else begin
            $display("%0s: lock stayed high for two cycles", test_name);
            count = count + 1;
        end
        assert (!(rst_l && top_prev && !top_out)) else begin
            $display("%0s: top_out fell while the game was over", test_name);
            count = count + 1;
        end
        assert (rst_l || (!lock && !top_out)) else begin
            $display("%0s: lock or top_out high during reset", test_name);
            count = count + 1;
        end
        lock_prev = lock;
        top_prev  = top_out;
    end

endmodule

/* testbench/tb_tetris.sv */
// keys are active low; each press is followed by a wait that covers the 20-cycle cooldown
`timescale 1ns/100ps

module tb_tetris;
    import board_pkg::*;
    import tetromino_pkg::*;

    localparam int COOLDOWN     = 20;
    localparam int PRESS_CYCLES = COOLDOWN + 8;
    // about 110 presses of about 32 cycles plus probe scans, with margin
    localparam int CYCLE_LIMIT  = 5000;

    logic clk = 1'b0;
    logic rst_l, rotate_mode, lock, top_out;
    logic [3:0] keys;
    row_t probe_row, piece_row, exp_row;
    col_t piece_col, exp_col;
    orientation_t piece_orientation, exp_ori, m_ori;
    tile_type_t piece_type, m_kind, exp_kind;
    bag_t bag_remaining, group_mask;
    row_cells_t probe_cells, exp_cells;
    logic [127:0] test_name;
    logic chk_piece, chk_probe, chk_bag, chk_group, exp_top;
    int exp_bag_count, prop_errors, tb_errors, cycles, start_errors, failing, guard;
    int m_row, m_col, spawns;
    bit m_top;
    row_cells_t field [PLAYFIELD_ROWS];
    tile_type_t kinds [$];

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

    tetris_core #(.COOLDOWN_CYCLES(COOLDOWN)) i_dut (
        .clk(clk), .rst_l(rst_l), .key_left(keys[0]), .key_right(keys[1]),
        .key_soft(keys[2]), .key_hard(keys[3]), .rotate_mode(rotate_mode),
        .piece_type(piece_type), .piece_row(piece_row), .piece_col(piece_col),
        .piece_orientation(piece_orientation), .lock(lock), .top_out(top_out),
        .bag_remaining(bag_remaining), .probe_row(probe_row), .probe_cells(probe_cells)
    );

    tb_tetris_props i_props (.*, .errors(prop_errors));

    function automatic orientation_t turn(orientation_t o, int step);
        logic [1:0] v;
        v = o + step[1:0];
        return orientation_t'(v);
    endfunction

    function automatic bit fits_model(tile_type_t k, orientation_t o, int r, int c);
        shape_t s;
        int rr, cc;
        s = shape_cells(k, o);
        for (int i = 0; i < CELLS_PER_PIECE; i++) begin
            rr = r + int'(s.row[i]);
            cc = c + int'(s.col[i]);
            if (rr >= PLAYFIELD_ROWS || cc < 0 || cc >= PLAYFIELD_COLS) return 1'b0;
            if (field[rr][cc]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic push(int k, int hold);
        @(posedge clk);
        keys[k] <= 1'b0;
        repeat (hold) @(posedge clk);
        keys[k] <= 1'b1;
    endtask

    task automatic check_piece();
        exp_kind  = m_kind;
        exp_row   = row_t'(m_row);
        exp_col   = col_t'(m_col);
        exp_ori   = m_ori;
        exp_top   = m_top;
        chk_piece = 1'b1;
        @(negedge clk);
        chk_piece = 1'b0;
    endtask

    task automatic check_rows();
        for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
            @(posedge clk);
            probe_row <= row_t'(r);
            @(negedge clk);
            exp_cells = field[r];
            chk_probe = 1'b1;
            @(negedge clk);
            chk_probe = 1'b0;
        end
    endtask

    // new piece and bag state, called once the spawn has settled
    task automatic spawn_model();
        m_row  = 0;
        m_col  = 3;
        m_ori  = SPAWN;
        m_kind = piece_type;
        spawns++;
        kinds.push_back(m_kind);
        if (!fits_model(m_kind, m_ori, m_row, m_col)) m_top = 1'b1;
        exp_bag_count = 7 - spawns % 7;
        chk_bag = 1'b1;
        @(negedge clk);
        chk_bag = 1'b0;
    endtask

    task automatic act(action_t a, int hold, bit twice);
        int k;
        bit expect_lock, seen;
        shape_t s;
        k = (a == MOVE_L || a == ROT_L) ? 0 : (a == MOVE_R || a == ROT_R) ? 1 :
            (a == SOFT) ? 2 : 3;
        expect_lock = 1'b0;
        seen = 1'b0;
        if (!m_top) begin
            case (a)
                MOVE_L: if (fits_model(m_kind, m_ori, m_row, m_col - 1)) m_col--;
                MOVE_R: if (fits_model(m_kind, m_ori, m_row, m_col + 1)) m_col++;
                ROT_L: if (fits_model(m_kind, turn(m_ori, 3), m_row, m_col)) m_ori = turn(m_ori, 3);
                ROT_R: if (fits_model(m_kind, turn(m_ori, 1), m_row, m_col)) m_ori = turn(m_ori, 1);
                SOFT: begin
                    if (fits_model(m_kind, m_ori, m_row + 1, m_col)) m_row++;
                    else expect_lock = 1'b1;
                end
                default: begin
                    while (fits_model(m_kind, m_ori, m_row + 1, m_col)) m_row++;
                    expect_lock = 1'b1;
                end
            endcase
        end
        @(posedge clk);
        rotate_mode <= (a == ROT_L || a == ROT_R);
        push(k, hold);
        if (twice) begin
            repeat (2) @(posedge clk);
            push(k, hold);
        end
        if (expect_lock) begin
            for (int i = 0; i < 10 && !seen; i++) begin
                @(negedge clk);
                seen = lock;
            end
            if (!seen) begin
                $display("%0s: lock never pulsed after %0s", test_name, a.name());
                tb_errors++;
            end
            // the piece still sits at its final position while lock is high
            check_piece();
            s = shape_cells(m_kind, m_ori);
            for (int i = 0; i < CELLS_PER_PIECE; i++) begin
                field[m_row + int'(s.row[i])][m_col + int'(s.col[i])] = 1'b1;
            end
        end
        repeat (PRESS_CYCLES) @(posedge clk);
        @(negedge clk);
        if (expect_lock) spawn_model();
        check_piece();
    endtask

    task automatic begin_test(logic [127:0] name);
        test_name    = name;
        start_errors = prop_errors + tb_errors;
    endtask

    task automatic end_test(int num);
        int n;
        n = prop_errors + tb_errors - start_errors;
        if (n != 0) failing++;
        $display("test %0d %0s: %0s (%0d errors)", num, test_name, (n == 0) ? "ok" : "bad", n);
    endtask

    initial begin
        void'($urandom(32'h9717));
        rst_l = 1'b0;
        keys = 4'hF;
        rotate_mode = 1'b0;
        probe_row = '0;
        {chk_piece, chk_probe, chk_bag, chk_group} = '0;
        foreach (field[r]) field[r] = '0;
        repeat (8) @(posedge clk);
        rst_l <= 1'b1;

        begin_test("reset");
        repeat (4) @(posedge clk);
        @(negedge clk);
        spawn_model();
        check_piece();
        check_rows();
        end_test(1);

        begin_test("movement");
        repeat (6) act(MOVE_L, 4, 1'b0);
        repeat (9) act(MOVE_R, 4, 1'b0);
        act(MOVE_L, 40, 1'b0);
        act(MOVE_L, 3, 1'b1);
        repeat (5) act(($urandom % 2) ? MOVE_L : MOVE_R, 4, 1'b0);
        end_test(2);

        begin_test("rotation");
        repeat (4) act(ROT_R, 4, 1'b0);
        repeat (4) act(ROT_L, 4, 1'b0);
        act(ROT_R, 4, 1'b0);
        repeat (5) act(MOVE_L, 4, 1'b0);
        repeat (6) act(($urandom % 2) ? ROT_L : ROT_R, 4, 1'b0);
        end_test(3);

        begin_test("soft drop");
        guard = spawns;
        for (int i = 0; i < 24 && spawns == guard; i++) act(SOFT, 4, 1'b0);
        if (spawns == guard) begin
            $display("soft drop: the piece never locked");
            tb_errors++;
        end
        check_rows();
        end_test(4);

        begin_test("hard drop/bag");
        while (spawns < 14 && !m_top) begin
            guard = $urandom % 3;
            for (int i = 0; i < guard; i++) act(($urandom % 2) ? MOVE_L : MOVE_R, 4, 1'b0);
            act(HARD, 4, 1'b0);
        end
        check_rows();
        for (int g = 0; 7 * g + 6 < kinds.size(); g++) begin
            group_mask = '0;
            for (int j = 0; j < 7; j++) group_mask[kinds[7 * g + j]] = 1'b1;
            chk_group = 1'b1;
            @(negedge clk);
            chk_group = 1'b0;
        end
        end_test(5);

        begin_test("top-out");
        for (int i = 0; i < 25 && !m_top; i++) act(HARD, 4, 1'b0);
        if (!m_top) begin
            $display("top-out: the stack never reached the spawn position");
            tb_errors++;
        end
        repeat (4) act(action_t'(1 + $urandom % 6), 4, 1'b0);
        end_test(6);

        $display("tests run 6, failing %0d, errors %0d", failing, prop_errors + tb_errors);
        if (prop_errors + tb_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/board_pkg.sv
verilog/tetromino_pkg.sv
verilog/piece_if.sv
verilog/key_conditioner.sv
verilog/seven_bag.sv
verilog/move_checker.sv
verilog/falling_piece.sv
verilog/playfield.sv
verilog/tetris_core.sv
testbench/tb_tetris_props.sv
testbench/tb_tetris.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator and run; pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_tetris -o tb_tetris > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_tetris > sim.log 2>&1
cat sim.log

grep -qx "Test passed" sim.log && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
